// File: mem_pkg.sv
`default_nettype none

package mem_pkg;

    // core side, one 32-bit instruction word per address
    localparam int unsigned CORE_ADDR_W = 12;
    localparam int unsigned WORD_W = 32;

    // memory side moves 16-byte blocks
    localparam int unsigned MEM_ADDR_W = 10;
    localparam int unsigned MEM_DATA_W = 128;

    // a 64-byte line takes four block transfers
    localparam int unsigned XFERS_PER_LINE = 4;
    localparam int unsigned XFER_SEL_BITS = $clog2(XFERS_PER_LINE);
    // counters that must hold the full transfer count
    localparam int unsigned XFER_CNT_W = XFER_SEL_BITS + 1;

    // cycles from block request to block response
    localparam int unsigned MEM_LATENCY = 2;

endpackage

`default_nettype wire

// File: cache_pkg.sv
`default_nettype none

package cache_pkg;

    // geometry
    localparam int unsigned SETS = 4;
    localparam int unsigned WAYS = 2;
    localparam int unsigned WAY_BITS = 1;
    localparam int unsigned IDX_BITS = 2;
    localparam int unsigned LINE_WORDS = 16;

    // word address is split as tag | set | word in line
    localparam int unsigned WORD_SEL_BITS = 4;
    localparam int unsigned TAG_W = mem_pkg::CORE_ADDR_W - WORD_SEL_BITS - IDX_BITS;
    localparam int unsigned IDX_LSB = WORD_SEL_BITS;
    localparam int unsigned TAG_LSB = WORD_SEL_BITS + IDX_BITS;

    // fsm encodings
    localparam logic [1:0] ST_RESET = 2'd0;
    localparam logic [1:0] ST_READY = 2'd1;
    localparam logic [1:0] ST_MISS = 2'd2;

    // one line, read by word from the core side and filled by quad from memory
    typedef union packed {
        logic [LINE_WORDS-1:0][mem_pkg::WORD_W-1:0] w;
        logic [mem_pkg::XFERS_PER_LINE-1:0][mem_pkg::MEM_DATA_W-1:0] q;
    } cache_line_t;

endpackage

`default_nettype wire

// File: fetch_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fetch_if;

    logic req_valid;
    logic [mem_pkg::CORE_ADDR_W-1:0] req_addr;
    logic req_ready;
    logic rsp_valid;
    logic [mem_pkg::WORD_W-1:0] rsp_data;
    // wrong-path level, also lets a request in while req_ready is low
    logic flush;

    modport cache (
        input  req_valid, req_addr, flush,
        output req_ready, rsp_valid, rsp_data
    );

    modport core (
        output req_valid, req_addr, flush,
        input  req_ready, rsp_valid, rsp_data
    );

endinterface

`default_nettype wire

// File: mem_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_if;

    logic req_valid;
    // 16-byte block address
    logic [mem_pkg::MEM_ADDR_W-1:0] req_addr;
    logic rsp_valid;
    logic [mem_pkg::MEM_DATA_W-1:0] rsp_data;
    // memory never stalls on this one
    logic rsp_ready;

    modport cache (
        output req_valid, req_addr, rsp_ready,
        input  rsp_valid, rsp_data
    );

    modport mem (
        input  req_valid, req_addr, rsp_ready,
        output rsp_valid, rsp_data
    );

endinterface

`default_nettype wire

// File: icache_lru.sv
`timescale 1ns/1ps
`default_nettype none

module icache_lru (
    input  logic clk,
    input  logic rst,
    input  logic [cache_pkg::IDX_BITS-1:0] set_idx,
    input  logic touch,
    input  logic [cache_pkg::IDX_BITS-1:0] touch_set,
    input  logic [cache_pkg::WAY_BITS-1:0] touch_way,
    output logic [cache_pkg::WAY_BITS-1:0] victim_way
);

    // age 0 is most recent, WAYS-1 is the next to go
    logic [cache_pkg::WAY_BITS-1:0] age [cache_pkg::WAYS][cache_pkg::SETS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < cache_pkg::WAYS; w++) begin
                for (int s = 0; s < cache_pkg::SETS; s++) begin
                    age[w][s] <= (cache_pkg::WAY_BITS)'(w);
                end
            end
        end else if (touch) begin
            // ages are a permutation, so the oldest never wraps
            for (int w = 0; w < cache_pkg::WAYS; w++) begin
                if (age[w][touch_set] < age[touch_way][touch_set]) begin
                    age[w][touch_set] <= age[w][touch_set] + (cache_pkg::WAY_BITS)'(1);
                end
            end
            age[touch_way][touch_set] <= '0;
        end
    end

    always_comb begin
        victim_way = '0;
        for (int w = 0; w < cache_pkg::WAYS; w++) begin
            if (age[w][set_idx] == (cache_pkg::WAY_BITS)'(cache_pkg::WAYS - 1)) begin
                victim_way = (cache_pkg::WAY_BITS)'(w);
            end
        end
    end

endmodule

`default_nettype wire

// File: icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache (
    input  logic clk,
    input  logic rst,
    fetch_if.cache fetch,
    mem_if.cache mem
);

    logic a_valid [cache_pkg::WAYS][cache_pkg::SETS];
    logic [cache_pkg::TAG_W-1:0] a_tag [cache_pkg::WAYS][cache_pkg::SETS];
    cache_pkg::cache_line_t a_data [cache_pkg::WAYS][cache_pkg::SETS];

    logic new_req;
    logic [cache_pkg::IDX_BITS-1:0] req_set;
    logic [cache_pkg::TAG_W-1:0] req_tag;
    logic hit;
    logic [cache_pkg::WAY_BITS-1:0] hit_way;
    logic [cache_pkg::WAY_BITS-1:0] victim_way;

    // request registered for its response cycle
    logic new_req_d;
    logic hit_d;
    logic [mem_pkg::CORE_ADDR_W-1:0] addr_d;
    logic [cache_pkg::WAY_BITS-1:0] way_d;

    // the miss being refilled
    logic pend_active;
    logic [mem_pkg::CORE_ADDR_W-1:0] pend_addr;
    logic [cache_pkg::WAY_BITS-1:0] pend_way;
    logic [cache_pkg::IDX_BITS-1:0] pend_set;

    logic [1:0] state;
    logic [1:0] nx_state;
    logic miss_start;
    logic hit_rsp;
    logic pend_rsp;

    logic [mem_pkg::XFER_CNT_W-1:0] req_cnt;
    logic [mem_pkg::XFER_SEL_BITS-1:0] rsp_cnt;
    logic [mem_pkg::XFER_CNT_W-1:0] inflight;
    logic [mem_pkg::XFER_CNT_W-1:0] inflight_nx;
    // blocks still owed by memory to a refill that a flush abandoned
    logic [mem_pkg::XFER_CNT_W-1:0] stale;
    logic real_rsp;
    logic line_done;

    logic [cache_pkg::WAY_BITS-1:0] rd_way;
    logic [cache_pkg::IDX_BITS-1:0] rd_set;
    logic [cache_pkg::WORD_SEL_BITS-1:0] rd_word;
    logic [mem_pkg::CORE_ADDR_W-cache_pkg::WORD_SEL_BITS-1:0] fill_line;

    // a flush lets the new-path request in even while req_ready is low
    assign new_req = fetch.req_valid && (fetch.req_ready || fetch.flush);
    assign req_set = fetch.req_addr[cache_pkg::IDX_LSB +: cache_pkg::IDX_BITS];
    assign req_tag = fetch.req_addr[cache_pkg::TAG_LSB +: cache_pkg::TAG_W];

    always_comb begin
        hit = 1'b0;
        hit_way = '0;
        for (int w = 0; w < cache_pkg::WAYS; w++) begin
            if (a_valid[w][req_set] && (a_tag[w][req_set] == req_tag)) begin
                hit = 1'b1;
                hit_way = (cache_pkg::WAY_BITS)'(w);
            end
        end
    end

    icache_lru u_lru (
        .clk(clk),
        .rst(rst),
        .set_idx(req_set),
        .touch(hit_rsp || line_done),
        .touch_set(line_done ? pend_set : addr_d[cache_pkg::IDX_LSB +: cache_pkg::IDX_BITS]),
        .touch_way(line_done ? pend_way : way_d),
        .victim_way(victim_way)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            new_req_d <= 1'b0;
            hit_d <= 1'b0;
        end else begin
            new_req_d <= new_req;
            hit_d <= new_req && hit;
        end
    end

    // a miss carries its victim way forward
    always_ff @(posedge clk) begin
        if (new_req) begin
            addr_d <= fetch.req_addr;
            way_d <= hit ? hit_way : victim_way;
        end
    end

    assign miss_start = (state == cache_pkg::ST_READY) && new_req_d && !hit_d && !fetch.flush;
    assign hit_rsp = (state == cache_pkg::ST_READY) && new_req_d && hit_d && !fetch.flush;
    assign pend_rsp = (state == cache_pkg::ST_READY) && pend_active && !new_req_d
                      && !fetch.flush;

    always_ff @(posedge clk) begin
        if (rst) begin
            pend_active <= 1'b0;
        end else if (miss_start) begin
            pend_active <= 1'b1;
        end else if (pend_rsp || fetch.flush) begin
            pend_active <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (miss_start) begin
            pend_addr <= addr_d;
            pend_way <= way_d;
        end
    end

    assign pend_set = pend_addr[cache_pkg::IDX_LSB +: cache_pkg::IDX_BITS];

    // memory answers in order, so stale blocks all come before new ones
    assign real_rsp = mem.rsp_valid && (stale == '0);
    assign line_done = real_rsp && (state == cache_pkg::ST_MISS) && !fetch.flush
                       && (rsp_cnt == (mem_pkg::XFER_SEL_BITS)'(mem_pkg::XFERS_PER_LINE - 1));
    assign inflight_nx = inflight + (mem_pkg::XFER_CNT_W)'(mem.req_valid)
                         - (mem_pkg::XFER_CNT_W)'(mem.rsp_valid);

    always_ff @(posedge clk) begin
        if (rst) begin
            req_cnt <= '0;
            rsp_cnt <= '0;
            inflight <= '0;
            stale <= '0;
        end else begin
            inflight <= inflight_nx;
            if (fetch.flush || line_done) begin
                req_cnt <= '0;
            end else if (mem.req_valid) begin
                req_cnt <= req_cnt + (mem_pkg::XFER_CNT_W)'(1);
            end
            if (fetch.flush) begin
                rsp_cnt <= '0;
            end else if (real_rsp) begin
                rsp_cnt <= rsp_cnt + (mem_pkg::XFER_SEL_BITS)'(1);
            end
            if (fetch.flush) begin
                stale <= inflight_nx;
            end else if (mem.rsp_valid && (stale != '0)) begin
                stale <= stale - (mem_pkg::XFER_CNT_W)'(1);
            end
        end
    end

    // a miss drops the victim at once, the refill sets it on its last quad
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < cache_pkg::WAYS; w++) begin
                for (int s = 0; s < cache_pkg::SETS; s++) begin
                    a_valid[w][s] <= 1'b0;
                end
            end
        end else begin
            if (new_req && !hit) begin
                a_valid[victim_way][req_set] <= 1'b0;
            end
            if (line_done) begin
                a_valid[pend_way][pend_set] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (line_done) begin
            a_tag[pend_way][pend_set] <= pend_addr[cache_pkg::TAG_LSB +: cache_pkg::TAG_W];
        end
    end

    // stale blocks land in a line that is still invalid
    always_ff @(posedge clk) begin
        if (mem.rsp_valid) begin
            a_data[pend_way][pend_set].q[rsp_cnt] <= mem.rsp_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cache_pkg::ST_RESET;
        end else begin
            state <= nx_state;
        end
    end

    always_comb begin
        nx_state = state;
        case (state)
            cache_pkg::ST_RESET: nx_state = cache_pkg::ST_READY;
            cache_pkg::ST_READY: begin
                if (miss_start) begin
                    nx_state = cache_pkg::ST_MISS;
                end
            end
            cache_pkg::ST_MISS: begin
                if (line_done || fetch.flush) begin
                    nx_state = cache_pkg::ST_READY;
                end
            end
            default: nx_state = cache_pkg::ST_RESET;
        endcase
    end

    // block 0 goes out in the miss detect cycle, blocks 1 to 3 from the miss state
    assign fill_line = (state == cache_pkg::ST_MISS)
                       ? pend_addr[mem_pkg::CORE_ADDR_W-1:cache_pkg::WORD_SEL_BITS]
                       : addr_d[mem_pkg::CORE_ADDR_W-1:cache_pkg::WORD_SEL_BITS];
    assign mem.req_valid = miss_start
                           || ((state == cache_pkg::ST_MISS) && !fetch.flush
                               && (req_cnt < (mem_pkg::XFER_CNT_W)'(mem_pkg::XFERS_PER_LINE)));
    assign mem.req_addr = {fill_line, req_cnt[mem_pkg::XFER_SEL_BITS-1:0]};
    assign mem.rsp_ready = (state == cache_pkg::ST_MISS);

    assign fetch.req_ready = (state == cache_pkg::ST_READY) && !miss_start;
    assign fetch.rsp_valid = hit_rsp || pend_rsp;

    always_comb begin
        if (pend_rsp) begin
            rd_way = pend_way;
            rd_set = pend_set;
            rd_word = pend_addr[cache_pkg::WORD_SEL_BITS-1:0];
        end else begin
            rd_way = way_d;
            rd_set = addr_d[cache_pkg::IDX_LSB +: cache_pkg::IDX_BITS];
            rd_word = addr_d[cache_pkg::WORD_SEL_BITS-1:0];
        end
    end

    assign fetch.rsp_data = a_data[rd_way][rd_set].w[rd_word];

endmodule

`default_nettype wire

// File: main_mem.sv
`timescale 1ns/1ps
`default_nettype none

module main_mem (
    input  logic clk,
    input  logic rst,
    mem_if.mem mem,
    input  logic load_en,
    input  logic [mem_pkg::CORE_ADDR_W-1:0] load_addr,
    input  logic [mem_pkg::WORD_W-1:0] load_data
);

    logic [mem_pkg::WORD_W-1:0] ram [2**mem_pkg::CORE_ADDR_W];
    logic [mem_pkg::MEM_DATA_W/mem_pkg::WORD_W-1:0][mem_pkg::WORD_W-1:0] rd_quad;

    // one stage per latency cycle, so a new request can enter every cycle
    logic [mem_pkg::MEM_LATENCY-1:0] vld_q;
    logic [mem_pkg::MEM_DATA_W-1:0] dat_q [mem_pkg::MEM_LATENCY];

    always_ff @(posedge clk) begin
        if (load_en) begin
            ram[load_addr] <= load_data;
        end
    end

    // four adjacent words form one block, lowest word in the low bits
    always_comb begin
        for (int i = 0; i < mem_pkg::MEM_DATA_W / mem_pkg::WORD_W; i++) begin
            rd_quad[i] = ram[{mem.req_addr,
                              (mem_pkg::CORE_ADDR_W - mem_pkg::MEM_ADDR_W)'(i)}];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= mem.req_valid;
            for (int s = 1; s < mem_pkg::MEM_LATENCY; s++) begin
                vld_q[s] <= vld_q[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        dat_q[0] <= rd_quad;
        for (int s = 1; s < mem_pkg::MEM_LATENCY; s++) begin
            dat_q[s] <= dat_q[s-1];
        end
    end

    assign mem.rsp_valid = vld_q[mem_pkg::MEM_LATENCY-1];
    assign mem.rsp_data = dat_q[mem_pkg::MEM_LATENCY-1];

endmodule

`default_nettype wire

// File: icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top (
    input  logic clk,
    input  logic rst,
    // core fetch port
    input  logic fetch_valid,
    input  logic [mem_pkg::CORE_ADDR_W-1:0] fetch_addr,
    output logic fetch_ready,
    input  logic fetch_flush,
    output logic resp_valid,
    output logic [mem_pkg::WORD_W-1:0] resp_data,
    // loader port into main memory
    input  logic load_en,
    input  logic [mem_pkg::CORE_ADDR_W-1:0] load_addr,
    input  logic [mem_pkg::WORD_W-1:0] load_data
);

    fetch_if fetch_bus ();
    mem_if mem_bus ();

    assign fetch_bus.req_valid = fetch_valid;
    assign fetch_bus.req_addr = fetch_addr;
    assign fetch_bus.flush = fetch_flush;
    assign fetch_ready = fetch_bus.req_ready;
    assign resp_valid = fetch_bus.rsp_valid;
    assign resp_data = fetch_bus.rsp_data;

    icache u_icache (
        .clk(clk),
        .rst(rst),
        .fetch(fetch_bus.cache),
        .mem(mem_bus.cache)
    );

    main_mem u_main_mem (
        .clk(clk),
        .rst(rst),
        .mem(mem_bus.mem),
        .load_en(load_en),
        .load_addr(load_addr),
        .load_data(load_data)
    );

endmodule

`default_nettype wire

// File: icache_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module icache_assertions (
    input logic clk,
    input logic rst,
    input logic miss_start,
    input logic req_valid,
    input logic req_ready,
    input logic rsp_valid,
    input logic flush,
    input logic mem_req_valid
);

    // block requests issued since the current miss began
    logic [2:0] blk_cnt;
    logic acc;
    logic acc_d;
    logic miss_q;
    logic miss_cyc;
    // set by a flush until the next request is accepted
    logic flushed;

    assign acc = req_valid && (req_ready || flush);
    // an accepted request with no response in the next cycle has missed
    // the miss then lasts until its response or a flush
    assign miss_cyc = (acc_d || miss_q) && !rsp_valid && !flush;

    always_ff @(posedge clk) begin
        if (rst) begin
            blk_cnt <= '0;
        end else if (miss_start) begin
            blk_cnt <= 3'd1;
        end else if (mem_req_valid) begin
            blk_cnt <= blk_cnt + 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_d <= 1'b0;
            miss_q <= 1'b0;
            flushed <= 1'b0;
        end else begin
            acc_d <= acc;
            miss_q <= miss_cyc;
            if (acc) begin
                flushed <= 1'b0;
            end else if (flush) begin
                flushed <= 1'b1;
            end
        end
    end

    a_no_ready_in_miss: assert property (@(posedge clk) disable iff (rst)
        miss_cyc |-> !req_ready)
        else $error("req_ready high during a miss");

    // a flush cancels every earlier request and nothing answers until a new one
    a_no_rsp_on_flush: assert property (@(posedge clk) disable iff (rst)
        (flush || flushed) |-> !rsp_valid)
        else $error("response given in or after a flush");

    a_four_blocks: assert property (@(posedge clk) disable iff (rst)
        (mem_req_valid && !miss_start) |-> (blk_cnt < 3'd4))
        else $error("more than four block requests in one miss");

endmodule

`default_nettype wire

// File: tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
    input  logic clk,
    input  logic rst,
    input  logic fetch_valid,
    input  logic [mem_pkg::CORE_ADDR_W-1:0] fetch_addr,
    input  logic fetch_ready,
    input  logic fetch_flush,
    input  logic resp_valid,
    input  logic [mem_pkg::WORD_W-1:0] resp_data,
    input  logic load_en,
    input  logic [mem_pkg::CORE_ADDR_W-1:0] load_addr,
    input  logic [mem_pkg::WORD_W-1:0] load_data,
    output logic idle,
    output int errors,
    output int checks
);

    // miss detect cycle to last block: three more requests, then the memory latency
    localparam int unsigned FILL_CYCLES = mem_pkg::XFERS_PER_LINE - 1 + mem_pkg::MEM_LATENCY;

    logic [mem_pkg::WORD_W-1:0] mem_m [2**mem_pkg::CORE_ADDR_W];
    logic vld_m [cache_pkg::WAYS][cache_pkg::SETS];
    logic [cache_pkg::TAG_W-1:0] tag_m [cache_pkg::WAYS][cache_pkg::SETS];
    int age_m [cache_pkg::WAYS][cache_pkg::SETS];

    // request accepted in the previous cycle
    logic pipe_v;
    logic pipe_hit;
    logic [mem_pkg::CORE_ADDR_W-1:0] pipe_addr;
    logic [cache_pkg::WAY_BITS-1:0] pipe_way;

    // miss being refilled, then waiting for its response slot
    logic miss_v;
    logic rsp_wait;
    int fill_cnt;
    logic [mem_pkg::CORE_ADDR_W-1:0] pend_addr;
    logic [cache_pkg::WAY_BITS-1:0] pend_way;

    logic first;
    logic acc;
    logic exp_ready;
    logic exp_v;
    logic [mem_pkg::WORD_W-1:0] exp_d;
    logic look_hit;
    logic [cache_pkg::WAY_BITS-1:0] look_way;
    logic [cache_pkg::IDX_BITS-1:0] look_set;
    logic [cache_pkg::TAG_W-1:0] look_tag;

    function automatic logic [cache_pkg::IDX_BITS-1:0] set_of(
        input logic [mem_pkg::CORE_ADDR_W-1:0] a
    );
        return a[cache_pkg::WORD_SEL_BITS +: cache_pkg::IDX_BITS];
    endfunction

    // touched way becomes youngest, every way younger than it ages by one
    task automatic lru_touch(input int s, input int way);
        int old;
        old = age_m[way][s];
        for (int w = 0; w < cache_pkg::WAYS; w++) begin
            if (age_m[w][s] < old) begin
                age_m[w][s] = age_m[w][s] + 1;
            end
        end
        age_m[way][s] = 0;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < cache_pkg::WAYS; w++) begin
                for (int s = 0; s < cache_pkg::SETS; s++) begin
                    vld_m[w][s] = 1'b0;
                    age_m[w][s] = w;
                end
            end
            pipe_v = 1'b0;
            miss_v = 1'b0;
            rsp_wait = 1'b0;
            first = 1'b1;
            errors = 0;
            checks = 0;
            idle <= 1'b1;
        end else begin
            if (load_en) begin
                mem_m[load_addr] = load_data;
            end
            acc = fetch_valid && (fetch_ready || fetch_flush);

            // ready drops in the reset cycle, the miss detect cycle and the whole refill
            exp_ready = !first && !miss_v && !(pipe_v && !pipe_hit && !fetch_flush);
            checks++;
            if (fetch_ready !== exp_ready) begin
                errors++;
                $display("MISMATCH fetch_ready exp %h got %h", exp_ready, fetch_ready);
            end

            // lookup sees the arrays and ages as they stood during this cycle
            look_hit = 1'b0;
            look_way = '0;
            look_set = set_of(fetch_addr);
            look_tag = fetch_addr[mem_pkg::CORE_ADDR_W-1 -: cache_pkg::TAG_W];
            if (acc) begin
                for (int w = 0; w < cache_pkg::WAYS; w++) begin
                    if (vld_m[w][look_set] && (tag_m[w][look_set] == look_tag)) begin
                        look_hit = 1'b1;
                        look_way = (cache_pkg::WAY_BITS)'(w);
                    end
                end
                if (!look_hit) begin
                    for (int w = 0; w < cache_pkg::WAYS; w++) begin
                        if (age_m[w][look_set] == cache_pkg::WAYS - 1) begin
                            look_way = (cache_pkg::WAY_BITS)'(w);
                        end
                    end
                end
            end

            exp_v = 1'b0;
            exp_d = '0;
            if (fetch_flush) begin
                miss_v = 1'b0;
                rsp_wait = 1'b0;
            end else if (rsp_wait) begin
                exp_v = 1'b1;
                exp_d = mem_m[pend_addr];
                rsp_wait = 1'b0;
            end else if (miss_v) begin
                fill_cnt++;
                if (fill_cnt == FILL_CYCLES) begin
                    vld_m[pend_way][set_of(pend_addr)] = 1'b1;
                    tag_m[pend_way][set_of(pend_addr)] =
                        pend_addr[mem_pkg::CORE_ADDR_W-1 -: cache_pkg::TAG_W];
                    lru_touch(set_of(pend_addr), pend_way);
                    miss_v = 1'b0;
                    rsp_wait = 1'b1;
                end
            end else if (pipe_v && pipe_hit) begin
                exp_v = 1'b1;
                exp_d = mem_m[pipe_addr];
                lru_touch(set_of(pipe_addr), pipe_way);
            end else if (pipe_v) begin
                miss_v = 1'b1;
                fill_cnt = 0;
                pend_addr = pipe_addr;
                pend_way = pipe_way;
            end

            if (resp_valid && !exp_v) begin
                errors++;
                $display("unexpected response with no outstanding request, data %h", resp_data);
            end else if (!resp_valid && exp_v) begin
                errors++;
                $display("MISMATCH resp_valid exp %h got %h", 1'b1, resp_valid);
            end else if (exp_v) begin
                checks++;
                if (resp_data !== exp_d) begin
                    errors++;
                    $display("MISMATCH resp_data exp %h got %h", exp_d, resp_data);
                end
            end

            // a miss drops its victim at once
            if (acc && !look_hit) begin
                vld_m[look_way][look_set] = 1'b0;
            end
            pipe_v = acc;
            pipe_hit = look_hit;
            pipe_addr = fetch_addr;
            pipe_way = look_way;
            first = 1'b0;
            idle <= !(pipe_v || miss_v || rsp_wait);
        end
    end

endmodule

`default_nettype wire

// File: tb_icache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_icache;

    localparam int unsigned LOAD_WORDS = 2 ** mem_pkg::CORE_ADDR_W;
    localparam int unsigned NUM_FETCHES = 400;
    localparam int unsigned WORST_MISS = 16;
    localparam int unsigned CYCLE_LIMIT = LOAD_WORDS + NUM_FETCHES * WORST_MISS + 200;

    logic clk;
    logic rst;
    logic fetch_valid;
    logic [mem_pkg::CORE_ADDR_W-1:0] fetch_addr;
    logic fetch_ready;
    logic fetch_flush;
    logic resp_valid;
    logic [mem_pkg::WORD_W-1:0] resp_data;
    logic load_en;
    logic [mem_pkg::CORE_ADDR_W-1:0] load_addr;
    logic [mem_pkg::WORD_W-1:0] load_data;

    logic chk_idle;
    int chk_errors;
    int chk_checks;

    logic [15:0] lfsr_state;
    logic [31:0] rnd;
    logic accepted;
    int issued;
    int cycles = 0;

    always begin
        clk = 1'b0;
        #2;
        clk = 1'b1;
        #2;
    end

    icache_top dut (
        .clk(clk),
        .rst(rst),
        .fetch_valid(fetch_valid),
        .fetch_addr(fetch_addr),
        .fetch_ready(fetch_ready),
        .fetch_flush(fetch_flush),
        .resp_valid(resp_valid),
        .resp_data(resp_data),
        .load_en(load_en),
        .load_addr(load_addr),
        .load_data(load_data)
    );

    tb_checker chk (
        .clk(clk),
        .rst(rst),
        .fetch_valid(fetch_valid),
        .fetch_addr(fetch_addr),
        .fetch_ready(fetch_ready),
        .fetch_flush(fetch_flush),
        .resp_valid(resp_valid),
        .resp_data(resp_data),
        .load_en(load_en),
        .load_addr(load_addr),
        .load_data(load_data),
        .idle(chk_idle),
        .errors(chk_errors),
        .checks(chk_checks)
    );

    bind icache icache_assertions u_assertions (
        .clk(clk),
        .rst(rst),
        .miss_start(miss_start),
        .req_valid(fetch.req_valid),
        .req_ready(fetch.req_ready),
        .rsp_valid(fetch.rsp_valid),
        .flush(fetch.flush),
        .mem_req_valid(mem.req_valid)
    );

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // most fetches hit four tags in sets 0 and 1, so two ways keep getting evicted
    task automatic pick_request();
        logic [31:0] sel;
        logic [31:0] bits;
        take_bits(3, sel);
        if (sel[2:0] == 3'd0) begin
            fetch_valid <= 1'b0;
        end else if (sel[2:0] == 3'd7) begin
            take_bits(12, bits);
            fetch_valid <= 1'b1;
            fetch_addr <= bits[11:0];
        end else begin
            take_bits(7, bits);
            fetch_valid <= 1'b1;
            fetch_addr <= {4'b0000, bits[6:5], 1'b0, bits[4], bits[3:0]};
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("timeout: fetches did not complete");
            $display("errors %0d checks %0d", chk_errors + 1, chk_checks);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        lfsr_state = 16'd18;
        rst = 1'b1;
        fetch_valid = 1'b0;
        fetch_addr = '0;
        fetch_flush = 1'b0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // fill main memory before any fetch
        for (int a = 0; a < LOAD_WORDS; a++) begin
            take_bits(32, rnd);
            @(posedge clk);
            load_en <= 1'b1;
            load_addr <= (mem_pkg::CORE_ADDR_W)'(a);
            load_data <= rnd;
        end
        @(posedge clk);
        load_en <= 1'b0;
        pick_request();

        issued = 0;
        while (issued < NUM_FETCHES) begin
            @(posedge clk);
            accepted = fetch_valid && (fetch_ready || fetch_flush);
            if (accepted) begin
                issued++;
            end
            if (issued >= NUM_FETCHES) begin
                fetch_valid <= 1'b0;
                fetch_flush <= 1'b0;
            end else begin
                take_bits(8, rnd);
                // roughly one cycle in twenty
                fetch_flush <= (rnd[7:0] < 8'd13);
                if (accepted || !fetch_valid) begin
                    pick_request();
                end
            end
        end

        // let the last responses come back, then watch for strays
        repeat (2) @(posedge clk);
        while (!chk_idle) begin
            @(posedge clk);
        end
        repeat (8) @(posedge clk);
        $display("errors %0d checks %0d", chk_errors, chk_checks);
        if (chk_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
mem_pkg.sv
cache_pkg.sv
fetch_if.sv
mem_if.sv
icache_lru.sv
icache.sv
main_mem.sv
icache_top.sv
icache_assertions.sv
tb_checker.sv
tb_icache.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_icache -f tb.f
	./obj_dir/Vtb_icache | tee /dev/stderr | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir
